// File: tb.f
+incdir+.
led_pkg.sv
led_sequencer.sv
led_chain_serializer.sv
led_output_stage.sv
led_panel_driver.sv
led_panel_props.sv
tb_led_panel_driver.sv

// File: Makefile
SIM  = obj_dir/Vtb_led_panel_driver
SRCS = $(wildcard *.sv *.svh)

all: run

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_led_panel_driver

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: tb_led_panel_driver.sv
`timescale 1ns/1ps
`include "led_consts.svh"

module tb_led_panel_driver;

    localparam int blank_cycles = 72;  // DUT default blanking_time.
    localparam int gap_cycles   = 20;
    localparam int cfg_cycles   = `LED_GCLK_PERIOD + 135;  // Worst gclk wait plus sequence.
    localparam int frame_cycles = `LED_GCLK_PERIOD +
                                  `LED_LINES * (blank_cycles + `LED_SEGS * (`LED_SEG_BITS + 1));
    localparam int run_cycles   = 2 * (cfg_cycles + frame_cycles) + 100;
    localparam int max_cycles   = 2 * run_cycles;  // Generous margin.

    // One expected sclk pulse.
    typedef struct packed {
        logic                     gs;     // Grayscale bit, row select valid.
        logic                     first;  // First bit of a line.
        logic                     eol;    // Last bit of a line.
        logic                     endc;   // Last readback bit.
        led_pkg::line_idx_t       line;
        logic                     lat;
        logic [2*`LED_CHAINS-1:0] sin;
    } pulse_t;

    logic                     clk;
    logic                     nrst;
    logic                     clk_enable;
    logic                     sof;
    logic                     start_config;
    led_pkg::cfg_word_t       config_data;
    logic                     wr_en;
    led_pkg::chain_idx_t      wr_chain;
    led_pkg::seg_idx_t        wr_seg;
    led_pkg::seg_word_t       wr_data;
    logic                     driver_sclk;
    logic                     driver_gclk;
    logic                     driver_lat;
    logic [2*`LED_CHAINS-1:0] drivers_sin;
    logic [`LED_LINES-1:0]    mux_out;
    logic                     eoc;
    logic                     end_config;

    pulse_t             exp_mem [4096];  // Expected pulse stream.
    logic [11:0]        exp_n = '0;      // Entries pushed.
    logic [11:0]        ptr;             // Pulses seen.
    pulse_t             exp_cur;
    logic [`LED_LINES-1:0] exp_mux;
    logic               exp_gclk;
    led_pkg::seg_word_t pix [`LED_CHAINS][`LED_SEGS];  // Copy of every written word.
    led_pkg::cfg_word_t new_cfg;
    int                 seed = 32'h6097;
    int                 gap_delay;
    int                 idle_cnt;        // Enabled cycles since the last sclk.
    int                 gclk_pos;        // Position in the grayscale segment.
    int                 eoc_count;
    int                 endc_count;
    int                 cycle_cnt = 0;
    int                 mism_errors = 0;
    int                 other_errors = 0;

    led_panel_driver u_led_panel_driver (
        .clk          (clk),
        .nrst         (nrst),
        .clk_enable   (clk_enable),
        .sof          (sof),
        .start_config (start_config),
        .config_data  (config_data),
        .wr_en        (wr_en),
        .wr_chain     (wr_chain),
        .wr_seg       (wr_seg),
        .wr_data      (wr_data),
        .driver_sclk  (driver_sclk),
        .driver_gclk  (driver_gclk),
        .driver_lat   (driver_lat),
        .drivers_sin  (drivers_sin),
        .mux_out      (mux_out),
        .eoc          (eoc),
        .end_config   (end_config)
    );

    bind led_sequencer led_panel_props u_props (
        .clk        (clk),
        .nrst       (nrst),
        .state      (state),
        .eoc        (eoc),
        .end_config (end_config)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign exp_cur = exp_mem[ptr];

    // One-hot row of the expected line.
    always_comb begin
        for (int i = 0; i < `LED_LINES; i++) begin
            exp_mux[i] = exp_cur.line == led_pkg::line_idx_t'(i);
        end
    end

    assign exp_gclk = clk_enable && gclk_pos != 0;  // Idle slot at count 0.

    task automatic push_bit(input logic gs, input logic first, input logic eol,
                            input logic endc, input led_pkg::line_idx_t line,
                            input logic lat, input logic [2*`LED_CHAINS-1:0] sin);
        exp_mem[exp_n] = '{gs, first, eol, endc, line, lat, sin};
        exp_n = exp_n + 12'd1;
    endtask

    // FCWRTEN, config word MSB first with WRTFC, READFC, readback window.
    task automatic push_config(input led_pkg::cfg_word_t word);
        for (int i = 0; i < `LED_LAT_FCWRTEN; i++) push_bit(0, 0, 0, 0, '0, 1'b1, '0);
        for (int i = 0; i < `LED_SEG_BITS; i++) begin
            push_bit(0, 0, 0, 0, '0, i >= `LED_SEG_BITS - `LED_LAT_WRTFC,
                     {(2*`LED_CHAINS){word[`LED_SEG_BITS - 1 - i]}});
        end
        for (int i = 0; i < `LED_LAT_READFC; i++) push_bit(0, 0, 0, 0, '0, 1'b1, '0);
        for (int i = 0; i < `LED_SEG_BITS; i++) begin
            push_bit(0, 0, 0, i == `LED_SEG_BITS - 1, '0, 1'b0, '0);
        end
    endtask

    task automatic push_frame();
        logic [2*`LED_CHAINS-1:0] sin;
        logic                     lat;
        for (int ln = 0; ln < `LED_LINES; ln++) begin
            for (int sg = 0; sg < `LED_SEGS; sg++) begin
                for (int k = 0; k < `LED_SEG_BITS; k++) begin
                    for (int ch = 0; ch < `LED_CHAINS; ch++) begin
                        sin[2*ch +: 2] = {2{pix[ch][sg][`LED_SEG_BITS - 1 - k]}};  // Pin pair.
                    end
                    if (sg < `LED_SEGS - 1) lat = k == `LED_SEG_BITS - 1;
                    else if (ln < `LED_LINES - 1) lat = k >= `LED_SEG_BITS - `LED_LAT_LATGS;
                    else lat = k >= `LED_SEG_BITS - `LED_LAT_LINERESET;
                    push_bit(1'b1, sg == 0 && k == 0,
                             sg == `LED_SEGS - 1 && k == `LED_SEG_BITS - 1,
                             1'b0, led_pkg::line_idx_t'(ln), lat, sin);
                end
            end
        end
    endtask

    task automatic write_pixels();
        for (int ch = 0; ch < `LED_CHAINS; ch++) begin
            for (int sg = 0; sg < `LED_SEGS; sg++) begin
                @(negedge clk);
                pix[ch][sg] = {16'($random(seed)), $random(seed)};
                wr_en    = 1'b1;
                wr_chain = led_pkg::chain_idx_t'(ch);
                wr_seg   = led_pkg::seg_idx_t'(sg);
                wr_data  = pix[ch][sg];
            end
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic pulse_sof();
        @(negedge clk);
        sof = 1'b1;
        @(negedge clk);
        sof = 1'b0;
    endtask

    // Stream pointer, idle run and pulse counters.
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ptr        <= '0;
            idle_cnt   <= 0;
            eoc_count  <= 0;
            endc_count <= 0;
        end else begin
            if (driver_sclk) begin
                ptr      <= ptr + 12'd1;
                idle_cnt <= 0;
            end else if (clk_enable) begin
                idle_cnt <= idle_cnt + 1;
            end
            if (eoc) eoc_count <= eoc_count + 1;
            if (end_config) endc_count <= endc_count + 1;
        end
    end

    // Grayscale segment model.
    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            gclk_pos <= 0;
        end else if (clk_enable) begin
            gclk_pos <= (gclk_pos + 1) % `LED_GCLK_PERIOD;  // Wraps each segment.
        end
    end

    a_extra: assert property (@(posedge clk) disable iff (!nrst) driver_sclk |-> ptr < exp_n)
        else begin
            other_errors++;
            $display("Unexpected sclk pulse at %0t beyond the expected stream", $time);
        end
    a_sin: assert property (@(posedge clk) disable iff (!nrst)
                            driver_sclk |-> drivers_sin == exp_cur.sin)
        else begin
            mism_errors++;
            $display("Mismatch at %0t: drivers_sin expected %h got %h", $time,
                     $sampled(exp_cur.sin), $sampled(drivers_sin));
        end
    a_lat: assert property (@(posedge clk) disable iff (!nrst)
                            driver_sclk |-> driver_lat == exp_cur.lat)
        else begin
            mism_errors++;
            $display("Mismatch at %0t: driver_lat expected %b got %b", $time,
                     $sampled(exp_cur.lat), $sampled(driver_lat));
        end
    a_eoc: assert property (@(posedge clk) disable iff (!nrst) driver_sclk |-> eoc == exp_cur.eol)
        else begin
            mism_errors++;
            $display("Mismatch at %0t: eoc expected %b got %b", $time,
                     $sampled(exp_cur.eol), $sampled(eoc));
        end
    a_endc: assert property (@(posedge clk) disable iff (!nrst)
                             driver_sclk |-> end_config == exp_cur.endc)
        else begin
            mism_errors++;
            $display("Mismatch at %0t: end_config expected %b got %b", $time,
                     $sampled(exp_cur.endc), $sampled(end_config));
        end
    a_pulse: assert property (@(posedge clk) disable iff (!nrst)
                              (eoc || end_config) |-> driver_sclk)
        else begin
            other_errors++;
            $display("Pulse on eoc or end_config without sclk at %0t", $time);
        end
    a_mux: assert property (@(posedge clk) disable iff (!nrst)
                            driver_sclk && exp_cur.gs |-> mux_out == exp_mux)
        else begin
            mism_errors++;
            $display("Mismatch at %0t: mux_out expected %b got %b", $time,
                     $sampled(exp_mux), $sampled(mux_out));
        end
    a_blank: assert property (@(posedge clk) disable iff (!nrst)
                              driver_sclk && exp_cur.first |-> idle_cnt >= blank_cycles)
        else begin
            mism_errors++;
            $display("Mismatch at %0t: idle_cycles expected >= %0d got %0d", $time,
                     blank_cycles, $sampled(idle_cnt));
        end
    a_gclk: assert property (@(posedge clk) disable iff (!nrst) driver_gclk == exp_gclk)
        else begin
            mism_errors++;
            $display("Mismatch at %0t: driver_gclk expected %b got %b", $time,
                     $sampled(exp_gclk), $sampled(driver_gclk));
        end
    a_gate: assert property (@(posedge clk) disable iff (!nrst)
                             !clk_enable |-> !driver_sclk && !driver_gclk)
        else begin
            other_errors++;
            $display("sclk or gclk toggled while clk_enable was low at %0t", $time);
        end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Errors: %0d mismatches, %0d other", mism_errors, other_errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        nrst         = 1'b0;
        clk_enable   = 1'b1;
        sof          = 1'b0;
        start_config = 1'b0;
        config_data  = '0;
        wr_en        = 1'b0;
        wr_chain     = '0;
        wr_seg       = '0;
        wr_data      = '0;
        push_config(`LED_DEFAULT_CONF);  // Boot sequence.
        repeat (2) @(negedge clk);
        assert (!driver_sclk && !driver_lat && !eoc && !end_config && mux_out == '0)
            else begin
                other_errors++;
                $display("Outputs not idle during reset at %0t", $time);
            end
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        write_pixels();  // Lands while the boot config runs.
        push_frame();
        while (endc_count < 1) @(negedge clk);
        pulse_sof();
        gap_delay = 50 + ($random(seed) & 1023);
        repeat (gap_delay) @(negedge clk);
        clk_enable = 1'b0;  // Stall mid-frame.
        repeat (gap_cycles) @(negedge clk);
        clk_enable = 1'b1;
        while (eoc_count < 3) @(negedge clk);
        new_cfg      = {16'($random(seed)), $random(seed)};
        start_config = 1'b1;  // Pending until the next gclk segment end.
        config_data  = new_cfg;
        @(negedge clk);
        start_config = 1'b0;
        while (eoc_count < `LED_LINES) @(negedge clk);
        push_config(new_cfg);  // Replaces the next frame.
        pulse_sof();
        while (endc_count < 2) @(negedge clk);
        write_pixels();
        push_frame();
        pulse_sof();
        while (eoc_count < 2 * `LED_LINES) @(negedge clk);
        repeat (20) @(negedge clk);
        assert (ptr == exp_n)
            else begin
                mism_errors++;
                $display("Mismatch at %0t: sclk_pulses expected %0d got %0d", $time, exp_n, ptr);
            end
        $display("Errors: %0d mismatches, %0d other", mism_errors, other_errors);
        if (mism_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: led_panel_props.sv
`timescale 1ns/1ps

module led_panel_props (
    input logic                clk,
    input logic                nrst,
    input led_pkg::seq_state_t state,
    input logic                eoc,
    input logic                end_config
);

    // Exactly one state bit set.
    a_state_onehot: assert property (@(posedge clk) disable iff (!nrst) $onehot(state))
        else $error("Sequencer state is not one-hot");

    // Line end only while shifting, then blanking or frame end.
    a_eoc_in_shift: assert property (@(posedge clk) disable iff (!nrst)
                                     eoc |-> state == led_pkg::SHIFT ##1
                                     (state == led_pkg::BLANKING ||
                                      state == led_pkg::WAIT_SOF))
        else $error("eoc outside SHIFT");

    a_endc_in_dump: assert property (@(posedge clk) disable iff (!nrst)
                                     end_config |-> state == led_pkg::DUMP_CONFIG ##1
                                     state == led_pkg::WAIT_SOF)
        else $error("end_config outside DUMP_CONFIG");  // Readback window only.

endmodule

// File: led_panel_driver.sv
`timescale 1ns/1ps
`include "led_consts.svh"

module led_panel_driver (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      clk_enable,
    input  logic                      sof,
    input  logic                      start_config,
    input  led_pkg::cfg_word_t        config_data,
    input  logic                      wr_en,
    input  led_pkg::chain_idx_t       wr_chain,
    input  led_pkg::seg_idx_t         wr_seg,
    input  led_pkg::seg_word_t        wr_data,
    output logic                      driver_sclk,
    output logic                      driver_gclk,
    output logic                      driver_lat,
    output logic [2*`LED_CHAINS-1:0]  drivers_sin,
    output logic [`LED_LINES-1:0]     mux_out,
    output logic                      eoc,
    output logic                      end_config
);

    logic                  shift_gs;
    logic                  shift_cfg;
    logic                  cfg_bit;
    led_pkg::seg_idx_t     seg_idx;
    led_pkg::bit_idx_t     bit_idx;
    led_pkg::line_idx_t    line_idx;
    logic                  lat_req;
    logic                  gclk_seg_end;
    logic [`LED_CHAINS-1:0] chain_bits;  // One serial bit per chain.

    led_sequencer u_sequencer (
        .clk          (clk),
        .nrst         (nrst),
        .clk_enable   (clk_enable),
        .sof          (sof),
        .start_config (start_config),
        .config_data  (config_data),
        .gclk_seg_end (gclk_seg_end),
        .shift_gs     (shift_gs),
        .shift_cfg    (shift_cfg),
        .cfg_bit      (cfg_bit),
        .seg_idx      (seg_idx),
        .bit_idx      (bit_idx),
        .line_idx     (line_idx),
        .lat_req      (lat_req),
        .driver_sclk  (driver_sclk),
        .eoc          (eoc),
        .end_config   (end_config)
    );

    // Shared selects, per-chain buffers.
    for (genvar i = 0; i < `LED_CHAINS; i++) begin : g_chain
        led_chain_serializer #(
            .chain_id (led_pkg::chain_idx_t'(i))
        ) u_serializer (
            .clk       (clk),
            .nrst      (nrst),
            .wr_en     (wr_en),
            .wr_chain  (wr_chain),
            .wr_seg    (wr_seg),
            .wr_data   (wr_data),
            .shift_gs  (shift_gs),
            .shift_cfg (shift_cfg),
            .cfg_bit   (cfg_bit),
            .seg_idx   (seg_idx),
            .bit_idx   (bit_idx),
            .chain_bit (chain_bits[i])
        );
    end

    led_output_stage u_output_stage (
        .clk          (clk),
        .nrst         (nrst),
        .clk_enable   (clk_enable),
        .chain_bits   (chain_bits),
        .lat_req      (lat_req),
        .line_idx     (line_idx),
        .driver_gclk  (driver_gclk),
        .gclk_seg_end (gclk_seg_end),
        .driver_lat   (driver_lat),
        .drivers_sin  (drivers_sin),
        .mux_out      (mux_out)
    );

endmodule

// File: led_output_stage.sv
`timescale 1ns/1ps
`include "led_consts.svh"

module led_output_stage (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      clk_enable,
    input  logic [`LED_CHAINS-1:0]    chain_bits,
    input  logic                      lat_req,
    input  led_pkg::line_idx_t        line_idx,
    output logic                      driver_gclk,
    output logic                      gclk_seg_end,
    output logic                      driver_lat,
    output logic [2*`LED_CHAINS-1:0]  drivers_sin,
    output logic [`LED_LINES-1:0]     mux_out
);

    localparam int gclk_w = $clog2(`LED_GCLK_PERIOD);

    logic [gclk_w-1:0] gclk_cnt;  // Position in the grayscale segment.

    // Free-running grayscale counter.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            gclk_cnt <= '0;
        end else if (clk_enable) begin
            if (gclk_seg_end) begin
                gclk_cnt <= '0;  // Wrap.
            end else begin
                gclk_cnt <= gclk_cnt + 1'b1;
            end
        end
    end

    assign gclk_seg_end = gclk_cnt == gclk_w'(`LED_GCLK_PERIOD - 1);
    assign driver_gclk  = clk_enable && gclk_cnt != '0;  // One idle slot per segment.

    // Falling edge gives lat hold margin around the sclk edge.
    always_ff @(negedge clk or negedge nrst) begin
        if (!nrst) begin
            driver_lat <= 1'b0;
        end else begin
            driver_lat <= lat_req;
        end
    end

    // Row select, one cycle behind the line counter.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mux_out <= '0;
        end else if (clk_enable) begin
            mux_out <= {{(`LED_LINES - 1){1'b0}}, 1'b1} << line_idx;
        end
    end

    // Each chain drives a pin pair.
    always_comb begin
        for (int i = 0; i < `LED_CHAINS; i++) begin
            drivers_sin[2*i +: 2] = {2{chain_bits[i]}};
        end
    end

endmodule

// File: led_chain_serializer.sv
`timescale 1ns/1ps
`include "led_consts.svh"

module led_chain_serializer #(
    parameter led_pkg::chain_idx_t chain_id = '0
) (
    input  logic                clk,
    input  logic                nrst,
    input  logic                wr_en,
    input  led_pkg::chain_idx_t wr_chain,
    input  led_pkg::seg_idx_t   wr_seg,
    input  led_pkg::seg_word_t  wr_data,
    input  logic                shift_gs,
    input  logic                shift_cfg,
    input  logic                cfg_bit,
    input  led_pkg::seg_idx_t   seg_idx,
    input  led_pkg::bit_idx_t   bit_idx,
    output logic                chain_bit
);

    led_pkg::seg_word_t    seg_mem [`LED_SEGS];  // Segment buffer of this chain.
    logic [`LED_SEGS-1:0]  seg_valid;            // Written since reset.
    logic                  wr_hit;
    logic                  gs_bit;

    assign wr_hit = wr_en && wr_chain == chain_id &&
                    wr_seg < led_pkg::seg_idx_t'(`LED_SEGS);

    // Host port, independent of clk_enable.
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            seg_mem[wr_seg] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            seg_valid <= '0;
        end else if (wr_hit) begin
            seg_valid[wr_seg] <= 1'b1;
        end
    end

    // Unwritten segments shift out as dark.
    assign gs_bit = seg_idx < led_pkg::seg_idx_t'(`LED_SEGS) && seg_valid[seg_idx] &&
                    seg_mem[seg_idx][bit_idx];

    always_comb begin
        if (shift_gs) begin
            chain_bit = gs_bit;
        end else if (shift_cfg) begin
            chain_bit = cfg_bit;  // Same word on every chain.
        end else begin
            chain_bit = 1'b0;
        end
    end

endmodule

// File: led_sequencer.sv
`timescale 1ns/1ps
`include "led_consts.svh"

module led_sequencer #(
    parameter int blanking_time = 72
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               clk_enable,
    input  logic               sof,
    input  logic               start_config,
    input  led_pkg::cfg_word_t config_data,
    input  logic               gclk_seg_end,
    output logic               shift_gs,
    output logic               shift_cfg,
    output logic               cfg_bit,
    output led_pkg::seg_idx_t  seg_idx,
    output led_pkg::bit_idx_t  bit_idx,
    output led_pkg::line_idx_t line_idx,
    output logic               lat_req,
    output logic               driver_sclk,
    output logic               eoc,
    output logic               end_config
);

    localparam int wrtfc_wait = 6;  // Settling time after WRTFC.
    localparam int dump_pause = 5;  // Sclk-free cycles after READFC.

    led_pkg::seq_state_t state;
    logic [15:0]         cnt;        // Cycles spent in the current state.
    led_pkg::cfg_word_t  cfg_buf;
    logic                pending;    // A config write is waiting.
    logic                last_seg;
    logic                last_line;
    logic                shift_end;  // Last bit of a segment.
    logic                enter_prep;
    led_pkg::bit_idx_t   cfg_sel;

    assign last_seg  = seg_idx == led_pkg::seg_idx_t'(`LED_SEGS - 1);
    assign last_line = line_idx == led_pkg::line_idx_t'(`LED_LINES - 1);
    assign shift_end = state == led_pkg::SHIFT && cnt == 16'(`LED_SEG_BITS - 1);

    // Both ways into PREP_CONFIG.
    assign enter_prep = clk_enable && (state == led_pkg::STALL ||
        (state == led_pkg::WAIT_GCLK_END && gclk_seg_end && pending));

    // Strobe is taken on any edge so it is never missed.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cfg_buf <= `LED_DEFAULT_CONF;
        end else if (start_config) begin
            cfg_buf <= config_data;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pending <= 1'b0;
        end else if (enter_prep) begin
            pending <= 1'b0;  // Served by this sequence.
        end else if (start_config) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= led_pkg::STALL;
            cnt      <= '0;
            seg_idx  <= '0;
            line_idx <= '0;
        end else if (clk_enable) begin
            cnt <= cnt + 16'd1;  // Default, cleared on every exit.
            unique case (state)
                led_pkg::STALL: begin
                    state <= led_pkg::PREP_CONFIG;
                    cnt   <= '0;
                end
                led_pkg::PREP_CONFIG: begin
                    if (cnt == 16'(`LED_LAT_FCWRTEN - 1)) begin
                        state <= led_pkg::CONFIG;
                        cnt   <= '0;
                    end
                end
                led_pkg::CONFIG: begin
                    if (cnt == 16'(`LED_SEG_BITS)) begin  // One lead cycle plus 48 bits.
                        state <= led_pkg::WRTFC_WAIT;
                        cnt   <= '0;
                    end
                end
                led_pkg::WRTFC_WAIT: begin
                    if (cnt == 16'(wrtfc_wait - 1)) begin
                        state <= led_pkg::PREP_DUMP;
                        cnt   <= '0;
                    end
                end
                led_pkg::PREP_DUMP: begin
                    if (cnt == 16'(`LED_LAT_READFC - 1)) begin
                        state <= led_pkg::DUMP_CONFIG;
                        cnt   <= '0;
                    end
                end
                led_pkg::DUMP_CONFIG: begin
                    if (cnt == 16'(`LED_SEG_BITS + dump_pause - 1)) begin
                        state <= led_pkg::WAIT_SOF;
                        cnt   <= '0;
                    end
                end
                led_pkg::WAIT_SOF: begin
                    cnt <= '0;
                    if (sof) begin
                        state    <= led_pkg::WAIT_GCLK_END;
                        line_idx <= '0;  // Frame restarts at the top row.
                        seg_idx  <= '0;
                    end
                end
                led_pkg::WAIT_GCLK_END: begin
                    cnt <= '0;
                    if (gclk_seg_end) begin
                        // Pending config replaces the frame.
                        state <= pending ? led_pkg::PREP_CONFIG : led_pkg::BLANKING;
                    end
                end
                led_pkg::BLANKING: begin
                    seg_idx <= '0;
                    if (cnt == 16'(blanking_time - 1)) begin
                        state <= led_pkg::PAUSE_SCLK;
                        cnt   <= '0;
                    end
                end
                led_pkg::PAUSE_SCLK: begin
                    state <= led_pkg::SHIFT;
                    cnt   <= '0;
                end
                led_pkg::SHIFT: begin
                    if (shift_end) begin
                        cnt <= '0;
                        if (!last_seg) begin
                            seg_idx <= seg_idx + 1'b1;
                            state   <= led_pkg::PAUSE_SCLK;
                        end else if (!last_line) begin
                            seg_idx  <= '0;
                            line_idx <= line_idx + 1'b1;
                            state    <= led_pkg::BLANKING;
                        end else begin
                            seg_idx  <= '0;
                            line_idx <= '0;
                            state    <= led_pkg::WAIT_SOF;  // Frame done.
                        end
                    end
                end
                default: begin
                    state <= led_pkg::STALL;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // Shift clock and latch windows.
    always_comb begin
        driver_sclk = 1'b0;
        lat_req     = 1'b0;
        case (state)
            led_pkg::PREP_CONFIG, led_pkg::PREP_DUMP: begin
                driver_sclk = clk_enable;
                lat_req     = 1'b1;  // Whole state is the command.
            end
            led_pkg::CONFIG: begin
                driver_sclk = clk_enable && cnt != 16'd0;  // Lead cycle is quiet.
                lat_req     = cnt >= 16'(`LED_SEG_BITS + 1 - `LED_LAT_WRTFC);
            end
            led_pkg::DUMP_CONFIG: begin
                driver_sclk = clk_enable && cnt >= 16'(dump_pause);
            end
            led_pkg::SHIFT: begin
                driver_sclk = clk_enable;
                if (last_seg && last_line) begin
                    lat_req = cnt >= 16'(`LED_SEG_BITS - `LED_LAT_LINERESET);
                end else if (last_seg) begin
                    lat_req = cnt >= 16'(`LED_SEG_BITS - `LED_LAT_LATGS);
                end else begin
                    lat_req = cnt == 16'(`LED_SEG_BITS - 1);  // Single-edge WRTGS.
                end
            end
            default: driver_sclk = 1'b0;
        endcase
    end

    assign shift_gs  = state == led_pkg::SHIFT;
    assign shift_cfg = state == led_pkg::CONFIG && cnt != 16'd0;

    // Config bit 48-c, MSB first from c of 1.
    assign cfg_sel = led_pkg::bit_idx_t'(16'(`LED_SEG_BITS) - cnt);
    assign cfg_bit = shift_cfg ? cfg_buf[cfg_sel] : 1'b0;

    assign bit_idx = led_pkg::bit_idx_t'(16'(`LED_SEG_BITS - 1) - cnt);  // MSB first.

    assign eoc        = shift_end && last_seg && clk_enable;
    assign end_config = state == led_pkg::DUMP_CONFIG && clk_enable &&
                        cnt == 16'(`LED_SEG_BITS + dump_pause - 1);

endmodule

// File: led_pkg.sv
`include "led_consts.svh"

package led_pkg;

    typedef logic [`LED_SEG_BITS-1:0] cfg_word_t;  // Function-config word.
    typedef logic [`LED_SEG_BITS-1:0] seg_word_t;  // One grayscale segment.

    typedef logic [$clog2(`LED_SEG_BITS)-1:0] bit_idx_t;  // Bit within a segment.
    typedef logic [$clog2(`LED_SEGS)-1:0] seg_idx_t;      // Segment number.
    typedef logic [$clog2(`LED_CHAINS)-1:0] chain_idx_t;  // Chain number.
    typedef logic [$clog2(`LED_LINES)-1:0] line_idx_t;    // Row number.

    // One-hot encoded sequencer states.
    typedef enum logic [10:0] {
        STALL         = 11'b000_0000_0001,  // One cycle after reset.
        PREP_CONFIG   = 11'b000_0000_0010,  // FCWRTEN latch.
        CONFIG        = 11'b000_0000_0100,  // Config word out, WRTFC at the end.
        WRTFC_WAIT    = 11'b000_0000_1000,
        PREP_DUMP     = 11'b000_0001_0000,  // READFC latch.
        DUMP_CONFIG   = 11'b000_0010_0000,  // Readback window.
        WAIT_SOF      = 11'b000_0100_0000,
        WAIT_GCLK_END = 11'b000_1000_0000,
        BLANKING      = 11'b001_0000_0000,
        PAUSE_SCLK    = 11'b010_0000_0000,
        SHIFT         = 11'b100_0000_0000   // Grayscale data out.
    } seq_state_t;

endpackage

// File: led_consts.svh
`ifndef LED_CONSTS_SVH
`define LED_CONSTS_SVH

// Panel geometry.
`define LED_CHAINS 4      // Driver chains in parallel.
`define LED_SEG_BITS 48   // Bits per segment, also the config word length.
`define LED_SEGS 3        // Segments per chain and line.
`define LED_LINES 8       // Multiplexed rows.

// Grayscale clock segment length, in enabled cycles.
`define LED_GCLK_PERIOD 129

// Latch command widths, counted in sclk rising edges with lat high.
`define LED_LAT_FCWRTEN 15   // Enable function-config write.
`define LED_LAT_READFC 11    // Read back function config.
`define LED_LAT_WRTFC 5      // Write function config.
`define LED_LAT_LATGS 3      // Last segment of a line.
`define LED_LAT_LINERESET 7  // Last segment of the frame.

// Boot configuration word, shifted MSB first.
`define LED_DEFAULT_CONF 48'h043F_A01C_78E5

`endif
